//--- dcache_pkg.sv
// data cache shared types: geometry, address split, line frame, requests and controller states
package dcache_pkg;

   localparam int IDX_W           = 3;
   localparam int TAG_W           = 26;
   localparam int SETS            = 8;
   localparam int WAYS            = 2;
   localparam int WORDS_PER_BLOCK = 2;

   typedef logic [31:0] word_t;
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [IDX_W-1:0] idx_t;
   typedef logic [$clog2(WAYS)-1:0] way_t;
   typedef logic [$clog2(WORDS_PER_BLOCK)-1:0] blkoff_t;

   // word address as the cache sees it
   typedef struct packed {
      tag_t       tag;
      idx_t       idx;
      blkoff_t    blkoff;
      logic [1:0] bytoff;   // always 0 for word accesses
   } dcache_addr_t;

   typedef struct packed {
      logic                             valid;
      logic                             dirty;
      tag_t                             tag;
      word_t [WORDS_PER_BLOCK-1:0]      data;
   } frame_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t wdata;
   } cpu_req_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t wdata;
   } mem_req_t;

   // line write commands from the controller to the frame store
   typedef enum logic [2:0] {NONE, CPU_WRITE, FILL_WORD, FILL_DONE, CLEAN} frame_op_t;

   typedef struct packed {
      frame_op_t op;
      way_t      way;
      idx_t      idx;
      blkoff_t   blkoff;
      word_t     data;
   } frame_cmd_t;

   typedef enum logic [3:0] {
      IDLE, WB0, WB1, FILL0, FILL1, FLUSH_SCAN, FLUSH0, FLUSH1, HALTED
   } dcache_state_t;

endpackage

//--- dcache_frames.sv
// data cache frame store: tag, valid, dirty and data for both ways, with lookup and line writes
`timescale 1ns/1ns

module dcache_frames (
   input  logic                     CLK,
   input  logic                     nRST,
   input  dcache_pkg::dcache_addr_t addr,
   input  dcache_pkg::idx_t         sel_idx,
   input  dcache_pkg::way_t         sel_way,
   input  dcache_pkg::frame_cmd_t   cmd,
   output logic                     hit,
   output dcache_pkg::way_t         hit_way,
   output dcache_pkg::word_t        rdata,
   output dcache_pkg::frame_t       sel_frame
);

   dcache_pkg::frame_t frames [dcache_pkg::WAYS][dcache_pkg::SETS];   // way x set
   logic [dcache_pkg::WAYS-1:0] match;

   // tag compare in both ways at the request index
   always_comb begin
      for (int w = 0; w < dcache_pkg::WAYS; w++) begin
         match[w] = frames[w][addr.idx].valid && (frames[w][addr.idx].tag == addr.tag);
      end
   end

   assign hit       = |match;
   assign hit_way   = dcache_pkg::way_t'(match[1]);   // way 0 unless way 1 matches
   assign rdata     = frames[hit_way][addr.idx].data[addr.blkoff];
   assign sel_frame = frames[sel_way][sel_idx];        // victim or flush line

   // line writes, one per cycle at most
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         frames <= '{default: '0};
      end else begin
         case (cmd.op)
            dcache_pkg::CPU_WRITE: begin
               frames[cmd.way][cmd.idx].data[cmd.blkoff] <= cmd.data;
               frames[cmd.way][cmd.idx].dirty            <= 1'b1;
            end
            dcache_pkg::FILL_WORD: begin
               frames[cmd.way][cmd.idx].data[cmd.blkoff] <= cmd.data;
            end
            dcache_pkg::FILL_DONE: begin
               // last word of the fill, line becomes valid for the request tag
               frames[cmd.way][cmd.idx].data[cmd.blkoff] <= cmd.data;
               frames[cmd.way][cmd.idx].tag              <= addr.tag;
               frames[cmd.way][cmd.idx].valid            <= 1'b1;
               frames[cmd.way][cmd.idx].dirty            <= 1'b0;
            end
            dcache_pkg::CLEAN: begin
               frames[cmd.way][cmd.idx].dirty <= 1'b0;   // memory copy now current
            end
            default: begin
            end
         endcase
      end
   end

   // a fill never installs a block that is already present in the other way
   a_one_way_hit: assert property (@(posedge CLK) disable iff (!nRST)
      $onehot0(match));

endmodule

//--- dcache_lru.sv
// data cache use bits: one bit per set naming the next victim way
`timescale 1ns/1ns

module dcache_lru (
   input  logic              CLK,
   input  logic              nRST,
   input  dcache_pkg::idx_t  idx,
   input  logic              touch,
   input  dcache_pkg::way_t  touch_way,
   output dcache_pkg::way_t  victim
);

   logic [dcache_pkg::SETS-1:0] use_q;   // 0 evicts way 0, 1 evicts way 1

   // the way not touched last goes next
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         use_q <= '0;
      end else if (touch) begin
         use_q[idx] <= ~touch_way;
      end
   end

   assign victim = dcache_pkg::way_t'(use_q[idx]);

endmodule

//--- dcache_ctrl.sv
// data cache controller FSM: hits, dirty victim write-back, line fill and halt flush
`timescale 1ns/1ns

module dcache_ctrl (
   input  logic                   CLK,
   input  logic                   nRST,
   input  dcache_pkg::cpu_req_t   cpu,
   input  logic                   halt,
   input  logic                   hit,
   input  dcache_pkg::way_t       hit_way,
   input  dcache_pkg::word_t      rdata,
   input  dcache_pkg::frame_t     sel_frame,
   input  dcache_pkg::way_t       victim,
   input  logic                   dwait,
   input  dcache_pkg::word_t      dload,
   output logic                   dhit,
   output dcache_pkg::word_t      dmemload,
   output logic                   flushed,
   output dcache_pkg::mem_req_t   mem,
   output dcache_pkg::frame_cmd_t cmd,
   output dcache_pkg::idx_t       sel_idx,
   output dcache_pkg::way_t       sel_way,
   output logic                   touch,
   output dcache_pkg::way_t       touch_way
);

   dcache_pkg::dcache_state_t state_q, state_d;
   dcache_pkg::idx_t          flush_idx_q, flush_idx_d;
   dcache_pkg::way_t          flush_way_q, flush_way_d;
   dcache_pkg::way_t          vict_q, vict_d;       // victim way latched at the miss
   dcache_pkg::dcache_addr_t  req_addr;
   logic                      flushing, flush_last, advance;

   // tag, set, word number packed into a word address
   function automatic dcache_pkg::word_t blk_addr(input dcache_pkg::tag_t tag,
                                                  input dcache_pkg::idx_t idx,
                                                  input dcache_pkg::blkoff_t word);
      dcache_pkg::dcache_addr_t a;
      a.tag    = tag;
      a.idx    = idx;
      a.blkoff = word;
      a.bytoff = 2'b00;
      return a;
   endfunction

   assign req_addr   = cpu.addr;
   assign dmemload   = rdata;
   assign flushing   = state_q inside {dcache_pkg::FLUSH_SCAN, dcache_pkg::FLUSH0,
                                       dcache_pkg::FLUSH1};
   assign flush_last = (flush_idx_q == dcache_pkg::idx_t'(dcache_pkg::SETS - 1)) &&
                       (flush_way_q == dcache_pkg::way_t'(dcache_pkg::WAYS - 1));
   assign sel_idx    = flushing ? flush_idx_q : req_addr.idx;
   // in IDLE the frame store shows the current victim so the miss can pick its path
   assign sel_way    = flushing ? flush_way_q :
                       (state_q == dcache_pkg::IDLE) ? victim : vict_q;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state_q     <= dcache_pkg::IDLE;
         flush_idx_q <= '0;
         flush_way_q <= '0;
         vict_q      <= '0;
      end else begin
         state_q     <= state_d;
         flush_idx_q <= flush_idx_d;
         flush_way_q <= flush_way_d;
         vict_q      <= vict_d;
      end
   end

   always_comb begin
      state_d     = state_q;
      flush_idx_d = flush_idx_q;
      flush_way_d = flush_way_q;
      vict_d      = vict_q;
      advance     = 1'b0;
      dhit        = 1'b0;
      flushed     = 1'b0;
      mem         = '0;
      cmd         = '0;
      cmd.idx     = req_addr.idx;
      cmd.way     = vict_q;
      touch       = 1'b0;
      touch_way   = hit_way;
      case (state_q)
         dcache_pkg::IDLE: begin
            if (halt) begin
               flush_idx_d = '0;
               flush_way_d = '0;
               state_d     = dcache_pkg::FLUSH_SCAN;
            end else if ((cpu.ren || cpu.wen) && hit) begin
               dhit  = 1'b1;
               touch = 1'b1;
               if (cpu.wen) begin
                  cmd.op     = dcache_pkg::CPU_WRITE;
                  cmd.way    = hit_way;
                  cmd.blkoff = req_addr.blkoff;
                  cmd.data   = cpu.wdata;
               end
            end else if (cpu.ren || cpu.wen) begin
               vict_d  = victim;
               state_d = (sel_frame.valid && sel_frame.dirty) ? dcache_pkg::WB0 :
                                                                dcache_pkg::FILL0;
            end
         end
         dcache_pkg::WB0, dcache_pkg::WB1: begin
            mem.wen   = 1'b1;
            mem.addr  = blk_addr(sel_frame.tag, req_addr.idx, state_q == dcache_pkg::WB1);
            mem.wdata = sel_frame.data[state_q == dcache_pkg::WB1];
            if (!dwait) begin
               state_d = (state_q == dcache_pkg::WB0) ? dcache_pkg::WB1 : dcache_pkg::FILL0;
               if (state_q == dcache_pkg::WB1) begin
                  cmd.op = dcache_pkg::CLEAN;
               end
            end
         end
         dcache_pkg::FILL0, dcache_pkg::FILL1: begin
            mem.ren    = 1'b1;
            mem.addr   = blk_addr(req_addr.tag, req_addr.idx, state_q == dcache_pkg::FILL1);
            cmd.blkoff = state_q == dcache_pkg::FILL1;
            cmd.data   = dload;
            if (!dwait && (state_q == dcache_pkg::FILL0)) begin
               cmd.op  = dcache_pkg::FILL_WORD;
               state_d = dcache_pkg::FILL1;
            end else if (!dwait) begin
               cmd.op    = dcache_pkg::FILL_DONE;
               touch     = 1'b1;
               touch_way = vict_q;
               state_d   = dcache_pkg::IDLE;   // request hits on the next cycle
            end
         end
         dcache_pkg::FLUSH_SCAN: begin
            if (sel_frame.valid && sel_frame.dirty) begin
               state_d = dcache_pkg::FLUSH0;
            end else begin
               advance = 1'b1;
            end
         end
         dcache_pkg::FLUSH0, dcache_pkg::FLUSH1: begin
            mem.wen   = 1'b1;
            mem.addr  = blk_addr(sel_frame.tag, flush_idx_q, state_q == dcache_pkg::FLUSH1);
            mem.wdata = sel_frame.data[state_q == dcache_pkg::FLUSH1];
            if (!dwait && (state_q == dcache_pkg::FLUSH0)) begin
               state_d = dcache_pkg::FLUSH1;
            end else if (!dwait) begin
               cmd.op  = dcache_pkg::CLEAN;
               cmd.idx = flush_idx_q;
               cmd.way = flush_way_q;
               advance = 1'b1;
            end
         end
         dcache_pkg::HALTED: begin
            flushed = 1'b1;   // stays until reset
         end
         default: begin
            state_d = dcache_pkg::IDLE;
         end
      endcase
      // next line of the flush walk, way 0 sets 0..7 then way 1
      if (advance) begin
         if (flush_last) begin
            state_d = dcache_pkg::HALTED;
         end else begin
            flush_idx_d = dcache_pkg::idx_t'(flush_idx_q + 1'b1);
            if (flush_idx_q == dcache_pkg::idx_t'(dcache_pkg::SETS - 1)) begin
               flush_way_d = dcache_pkg::way_t'(flush_way_q + 1'b1);
            end
            state_d = dcache_pkg::FLUSH_SCAN;
         end
      end
   end

   a_mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem.ren && mem.wen));

   // once halted the cache stays flushed and quiet on the memory side
   a_halted_quiet: assert property (@(posedge CLK) disable iff (!nRST)
      (state_q == dcache_pkg::HALTED) |=>
         (state_q == dcache_pkg::HALTED) && flushed && !mem.ren && !mem.wen);

endmodule

//--- dcache.sv
// two-way write-back data cache top: controller, frame store and use bits
`timescale 1ns/1ns

module dcache (
   input  logic                 CLK,
   input  logic                 nRST,
   input  dcache_pkg::cpu_req_t cpu,
   input  logic                 halt,
   output logic                 dhit,
   output dcache_pkg::word_t    dmemload,
   output logic                 flushed,
   output dcache_pkg::mem_req_t mem,
   input  logic                 dwait,
   input  dcache_pkg::word_t    dload
);

   dcache_pkg::dcache_addr_t cpu_addr;   // request address split into fields
   dcache_pkg::frame_cmd_t   cmd;
   dcache_pkg::frame_t       sel_frame;
   dcache_pkg::idx_t         sel_idx;
   dcache_pkg::way_t         sel_way, hit_way, victim, touch_way;
   dcache_pkg::word_t        rdata;
   logic                     hit, touch;

   assign cpu_addr = cpu.addr;

   dcache_ctrl i_ctrl (
      .CLK       (CLK),
      .nRST      (nRST),
      .cpu       (cpu),
      .halt      (halt),
      .hit       (hit),
      .hit_way   (hit_way),
      .rdata     (rdata),
      .sel_frame (sel_frame),
      .victim    (victim),
      .dwait     (dwait),
      .dload     (dload),
      .dhit      (dhit),
      .dmemload  (dmemload),
      .flushed   (flushed),
      .mem       (mem),
      .cmd       (cmd),
      .sel_idx   (sel_idx),
      .sel_way   (sel_way),
      .touch     (touch),
      .touch_way (touch_way)
   );

   dcache_frames i_frames (
      .CLK       (CLK),
      .nRST      (nRST),
      .addr      (cpu_addr),
      .sel_idx   (sel_idx),
      .sel_way   (sel_way),
      .cmd       (cmd),
      .hit       (hit),
      .hit_way   (hit_way),
      .rdata     (rdata),
      .sel_frame (sel_frame)
   );

   dcache_lru i_lru (
      .CLK       (CLK),
      .nRST      (nRST),
      .idx       (cpu_addr.idx),
      .touch     (touch),
      .touch_way (touch_way),
      .victim    (victim)
   );

endmodule

//--- dcache_tb_mem.sv
// testbench memory: word-wide responder with random dwait and a log of finished transfers
`timescale 1ns/1ns

module dcache_tb_mem #(
   parameter int MAX_WAIT = 3,
   parameter int SEED     = 1
) (
   input  logic                 CLK,
   input  logic                 nRST,
   input  dcache_pkg::mem_req_t mem,
   output logic                 dwait,
   output dcache_pkg::word_t    dload
);

   localparam int DEPTH = 128;   // eight tags by eight sets by two words

   dcache_pkg::word_t ram [DEPTH];
   logic [64:0]       log_q [$];   // {wen, addr, data} per finished transfer
   int                seed;
   int                wait_q;      // dwait-high cycles left for this transfer
   logic              busy_q;
   logic              req;

   initial begin
      seed = SEED;
      for (int i = 0; i < DEPTH; i++) begin
         ram[i] = 32'hD000_0000 | (i << 2);   // pattern from the byte address
      end
   end

   assign req   = mem.ren || mem.wen;
   assign dwait = !(req && busy_q && (wait_q == 0));
   assign dload = ram[mem.addr[8:2]];

   always @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         busy_q <= 1'b0;
         wait_q <= 0;
      end else if (req && !busy_q) begin
         busy_q <= 1'b1;   // new transfer, pick its wait
         wait_q <= $unsigned($random(seed)) % (MAX_WAIT + 1);
      end else if (req && (wait_q != 0)) begin
         wait_q <= wait_q - 1;
      end else if (req) begin
         busy_q <= 1'b0;   // dwait low this cycle, transfer ends at the edge
         log_q.push_back({mem.wen, mem.addr, mem.wen ? mem.wdata : dload});
         if (mem.wen) begin
            ram[mem.addr[8:2]] <= mem.wdata;
         end
      end
   end

endmodule

//--- dcache_tb.sv
// data cache testbench running random loads and stores against a cache model, then a halt flush
`timescale 1ns/1ns

module dcache_tb;

   localparam int SEED     = 85734;
   localparam int OPS      = 400;
   localparam int MAX_WAIT = 3;
   localparam int WORDS    = 128;   // eight tags by eight sets by two words
   // up to four words per miss of MAX_WAIT + 2 cycles each, plus the flush walk
   localparam int TIMEOUT  = (OPS + 2 * dcache_pkg::SETS) * (4 * (MAX_WAIT + 2) + 4) * 20
                             + 1000;

   logic                 CLK = 1'b0;
   logic                 nRST;
   logic                 halt, dhit, flushed, dwait;
   dcache_pkg::cpu_req_t cpu;
   dcache_pkg::mem_req_t mem;
   dcache_pkg::word_t    dmemload, dload;

   // reference model of memory as the processor sees it, plus tags, state and use bits
   dcache_pkg::word_t    model_mem [WORDS];
   logic                 m_valid [dcache_pkg::WAYS][dcache_pkg::SETS];
   logic                 m_dirty [dcache_pkg::WAYS][dcache_pkg::SETS];
   dcache_pkg::tag_t     m_tag   [dcache_pkg::WAYS][dcache_pkg::SETS];
   logic                 m_use   [dcache_pkg::SETS];
   logic [64:0]          exp_q [$];   // predicted {wen, addr, data} transfers
   int                   seed;

   dcache i_dcache (
      .CLK      (CLK),
      .nRST     (nRST),
      .cpu      (cpu),
      .halt     (halt),
      .dhit     (dhit),
      .dmemload (dmemload),
      .flushed  (flushed),
      .mem      (mem),
      .dwait    (dwait),
      .dload    (dload)
   );

   dcache_tb_mem #(.MAX_WAIT(MAX_WAIT), .SEED(SEED)) i_mem (
      .CLK   (CLK),
      .nRST  (nRST),
      .mem   (mem),
      .dwait (dwait),
      .dload (dload)
   );

   always #10 CLK = ~CLK;

   task automatic compare(input string name, input logic [64:0] exp, input logic [64:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         $display("Test FAILED");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   function automatic dcache_pkg::word_t word_addr(input int tag, input int idx, input int w);
      return dcache_pkg::word_t'((tag * 16 + idx * 2 + w) << 2);
   endfunction

   // queue both word writes of a dirty line and mark it clean
   task automatic expect_writeback(input int way, input int idx);
      dcache_pkg::word_t a;
      for (int w = 0; w < 2; w++) begin
         a = word_addr(m_tag[way][idx], idx, w);
         exp_q.push_back({1'b1, a, model_mem[a[8:2]]});
      end
      m_dirty[way][idx] = 1'b0;
   endtask

   task automatic match_traffic(input string name);
      compare({name, " transfer count"}, exp_q.size(), i_mem.log_q.size());
      for (int i = 0; i < exp_q.size(); i++) begin
         compare($sformatf("%s transfer %0d", name, i), exp_q[i], i_mem.log_q[i]);
      end
      exp_q.delete();
      i_mem.log_q.delete();
   endtask

   task automatic access(input int n, input logic wr, input dcache_pkg::word_t addr,
                         input dcache_pkg::word_t data);
      dcache_pkg::dcache_addr_t a;
      dcache_pkg::word_t        fa;
      int                       way, idx, cycles;
      logic                     hit;
      a   = addr;
      idx = a.idx;
      hit = 1'b0;
      way = 0;
      for (int w = 0; w < 2; w++) begin
         if (m_valid[w][idx] && (m_tag[w][idx] == a.tag)) begin
            hit = 1'b1;
            way = w;
         end
      end
      if (!hit) begin
         way = m_use[idx];   // victim named by the use bit
         if (m_valid[way][idx] && m_dirty[way][idx]) begin
            expect_writeback(way, idx);
         end
         for (int w = 0; w < 2; w++) begin
            fa = word_addr(a.tag, idx, w);
            exp_q.push_back({1'b0, fa, model_mem[fa[8:2]]});
         end
         m_valid[way][idx] = 1'b1;
         m_tag[way][idx]   = a.tag;
      end
      m_use[idx] = (way == 0);
      @(posedge CLK);
      cpu    <= {!wr, wr, addr, data};
      cycles = 0;
      do begin
         @(negedge CLK);
         cycles++;
      end while (!dhit);
      if (hit) begin
         compare($sformatf("op %0d hit latency", n), 1, cycles);
      end
      match_traffic($sformatf("op %0d", n));
      if (wr) begin
         model_mem[addr[8:2]] = data;
         m_dirty[way][idx]    = 1'b1;
      end else begin
         compare($sformatf("op %0d read data", n), model_mem[addr[8:2]], dmemload);
      end
   endtask

   initial begin
      logic              wr;
      dcache_pkg::word_t addr, data;
      seed = SEED;
      nRST = 1'b0;
      halt = 1'b0;
      cpu  = '0;
      cpu.ren = 1'b1;   // a read of a cold line waits through reset
      for (int i = 0; i < WORDS; i++) begin
         model_mem[i] = 32'hD000_0000 | (i << 2);
      end
      for (int s = 0; s < dcache_pkg::SETS; s++) begin
         m_use[s] = 1'b0;
         for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            m_valid[w][s] = 1'b0;
            m_dirty[w][s] = 1'b0;
            m_tag[w][s]   = '0;
         end
      end
      repeat (2) @(posedge CLK);
      @(negedge CLK);
      compare("reset dhit", 0, dhit);   // every line invalid, so the read cannot hit
      @(posedge CLK);
      nRST <= 1'b1;
      cpu  <= '0;
      @(negedge CLK);
      compare("reset flushed", 0, flushed);
      compare("reset mem ren", 0, mem.ren);
      compare("reset mem wen", 0, mem.wen);

      for (int n = 0; n < OPS; n++) begin
         wr   = $random(seed) & 1;
         addr = ($random(seed) & 32'h7F) << 2;   // tag 0..7, any set, any word
         data = $random(seed);
         access(n, wr, addr, data);
      end

      // flush walk order is way 0 sets 0..7, then way 1
      for (int w = 0; w < dcache_pkg::WAYS; w++) begin
         for (int s = 0; s < dcache_pkg::SETS; s++) begin
            if (m_valid[w][s] && m_dirty[w][s]) begin
               expect_writeback(w, s);
            end
         end
      end
      @(posedge CLK);
      cpu  <= '0;
      halt <= 1'b1;
      do begin
         @(negedge CLK);
      end while (!flushed);
      match_traffic("flush");
      repeat (10) begin
         @(negedge CLK);
         compare("flushed held", 1, flushed);
         compare("halted mem request", 0, {mem.ren, mem.wen});
      end
      compare("halted transfers", 0, i_mem.log_q.size());
      for (int i = 0; i < WORDS; i++) begin
         compare($sformatf("memory word %0d", i), model_mem[i], i_mem.ram[i]);
      end
      $display("Test OK");
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT);
      $display("watchdog: cache run did not finish within %0d ns", TIMEOUT);
      $display("Test FAILED");
      $fatal(1, "timeout");
   end

endmodule

//--- sim.f
dcache_pkg.sv
dcache_frames.sv
dcache_lru.sv
dcache_ctrl.sv
dcache.sv
dcache_tb_mem.sv
dcache_tb.sv
